// ==== bench/mem_stage_assertions.sv ====
////////////////////////////////////////////////////////////////////////////
// mem_stage_assertions
// handshake and reset-state checks on the memory stage, bound to the top
////////////////////////////////////////////////////////////////////////////
module mem_stage_assertions (
    input logic                clock,
    input logic                reset,
    input logic                in_ready,
    input logic                out_valid,
    input logic                req_valid,
    input logic                req_ready,
    input logic                req_write,
    input rv_mem_pkg::addr_t   req_addr,
    input rv_mem_pkg::word_t   req_wdata,
    input mem_bus_pkg::strb_t  req_strb,
    input logic                rsp_valid,
    input logic                rsp_ready,
    input rv_mem_pkg::word_t   rsp_rdata,
    input mem_bus_pkg::rsp_t   rsp_resp
);

    int fail_count = 0;

    req_hold: assert property (@(posedge clock) disable iff (reset)
        req_valid && !req_ready |=> req_valid && $stable(req_write) && $stable(req_addr) &&
                                    $stable(req_wdata) && $stable(req_strb))
        else begin
            fail_count++;
            $error("request payload changed while stalled");
        end

    rsp_hold: assert property (@(posedge clock) disable iff (reset)
        rsp_valid && !rsp_ready |=> rsp_valid && $stable(rsp_rdata) && $stable(rsp_resp))
        else begin
            fail_count++;
            $error("response payload changed while stalled");
        end

    // one instruction in flight at a time
    no_req_with_result: assert property (@(posedge clock) disable iff (reset)
        !(req_valid && out_valid))
        else begin
            fail_count++;
            $error("request valid while a result is presented");
        end

    busy_blocks_input: assert property (@(posedge clock) disable iff (reset)
        req_valid |-> !in_ready)
        else begin
            fail_count++;
            $error("in_ready high while a request is pending");
        end

    reset_state: assert property (@(posedge clock)
        reset |-> in_ready && !out_valid && !req_valid && !rsp_valid)
        else begin
            fail_count++;
            $error("wrong handshake state during reset");
        end

endmodule

bind mem_stage_top mem_stage_assertions u_mem_stage_assertions (
    .clock     (clock),
    .reset     (reset),
    .in_ready  (in_ready),
    .out_valid (out_valid),
    .req_valid (lsu_req.valid),
    .req_ready (lsu_req.ready),
    .req_write (lsu_req.write),
    .req_addr  (lsu_req.addr),
    .req_wdata (lsu_req.wdata),
    .req_strb  (lsu_req.strb),
    .rsp_valid (lsu_rsp.valid),
    .rsp_ready (lsu_rsp.ready),
    .rsp_rdata (lsu_rsp.rdata),
    .rsp_resp  (lsu_rsp.resp)
);

// ==== bench/mem_stage_tb.sv ====
////////////////////////////////////////////////////////////////////////////
// mem_stage_tb
// directed tests of the memory stage against a byte-array memory model
////////////////////////////////////////////////////////////////////////////
module mem_stage_tb;

    localparam int NUM_BANKS    = 4;
    localparam int BANK_WORDS   = 64;
    localparam int BANK_LATENCY = 2;
    localparam int MEM_BYTES    = NUM_BANKS * BANK_WORDS * 4;
    localparam int TIMEOUT      = 20;    // cycles per wait

    logic                   clock;
    logic                   reset;
    logic                   in_valid;
    logic                   in_ready;
    logic                   mem_ren;
    logic                   mem_wen;
    logic                   reg_wen;
    logic                   out_valid;
    logic                   out_ready;
    logic                   reg_wen_out;
    rv_mem_pkg::addr_t      pc;
    rv_mem_pkg::addr_t      addr;
    rv_mem_pkg::addr_t      pc_out;
    rv_mem_pkg::funct3_t    funct3;
    rv_mem_pkg::word_t      store_data;
    rv_mem_pkg::word_t      load_data;
    rv_mem_pkg::reg_idx_t   rd;
    rv_mem_pkg::reg_idx_t   rd_out;
    rv_mem_pkg::stage_err_t err_out;

    logic [7:0] ref_mem [MEM_BYTES];    // little-endian byte image

    mem_stage_top #(
        .NUM_BANKS    (NUM_BANKS),
        .BANK_WORDS   (BANK_WORDS),
        .BANK_LATENCY (BANK_LATENCY)
    ) u_mem_stage_top (
        .clock, .reset, .in_valid, .in_ready, .pc, .mem_ren, .mem_wen, .reg_wen,
        .funct3, .addr, .store_data, .rd, .out_valid, .out_ready, .pc_out, .rd_out,
        .reg_wen_out, .load_data, .err_out
    );

    initial begin
        clock = 1'b0;
        forever #50 clock = ~clock;
    end

    task automatic abort_run();
        $display("TEST RESULT: FAIL");
        $fatal(1);
    endtask

    task automatic check_word(input string name, input rv_mem_pkg::word_t got,
                              input rv_mem_pkg::word_t exp);
        if (got !== exp) begin
            $display("FAILED time=%0t %s got=%h expected=%h", $time, name, got, exp);
            abort_run();
        end
    endtask

    task automatic check_reg(input string name, input rv_mem_pkg::reg_idx_t got,
                             input rv_mem_pkg::reg_idx_t exp);
        if (got !== exp) begin
            $display("FAILED time=%0t %s got=%0d expected=%0d", $time, name, got, exp);
            abort_run();
        end
    endtask

    task automatic check_err(input string name, input rv_mem_pkg::stage_err_t got,
                             input rv_mem_pkg::stage_err_t exp);
        if (got !== exp) begin
            $display("FAILED time=%0t %s got=%s expected=%s", $time, name,
                     got.name(), exp.name());
            abort_run();
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("FAILED time=%0t %s got=%b expected=%b", $time, name, got, exp);
            abort_run();
        end
    endtask

    task automatic model_store(input rv_mem_pkg::funct3_t f3, input rv_mem_pkg::addr_t a,
                               input rv_mem_pkg::word_t data);
        int n;
        n = (f3 == rv_mem_pkg::F3_B) ? 1 : (f3 == rv_mem_pkg::F3_H) ? 2 : 4;
        for (int i = 0; i < n; i++)
            ref_mem[a + i] = data[8*i +: 8];
    endtask

    function automatic rv_mem_pkg::word_t model_load(input rv_mem_pkg::funct3_t f3,
                                                     input rv_mem_pkg::addr_t a);
        case (f3)
            rv_mem_pkg::F3_B:  return {{24{ref_mem[a][7]}}, ref_mem[a]};
            rv_mem_pkg::F3_BU: return {24'd0, ref_mem[a]};
            rv_mem_pkg::F3_H:  return {{16{ref_mem[a+1][7]}}, ref_mem[a+1], ref_mem[a]};
            rv_mem_pkg::F3_HU: return {16'd0, ref_mem[a+1], ref_mem[a]};
            default:           return {ref_mem[a+3], ref_mem[a+2], ref_mem[a+1], ref_mem[a]};
        endcase
    endfunction

    // one instruction through the stage, returns once its result is shown
    task automatic run_instr(input logic ren, input logic wen, input logic wr_reg,
                             input rv_mem_pkg::funct3_t f3, input rv_mem_pkg::addr_t a,
                             input rv_mem_pkg::word_t data);
        rv_mem_pkg::addr_t    sent_pc;
        rv_mem_pkg::reg_idx_t dest;
        int                   n;
        sent_pc = $urandom;
        dest    = 5'($urandom);
        @(posedge clock);
        in_valid   <= 1'b1;
        mem_ren    <= ren;
        mem_wen    <= wen;
        reg_wen    <= wr_reg;
        funct3     <= f3;
        addr       <= a;
        store_data <= data;
        rd         <= dest;
        pc         <= sent_pc;
        n = 0;
        @(negedge clock);
        while (!in_ready) begin
            n++;
            if (n > TIMEOUT) begin
                $display("timeout waiting for in_ready at time %0t", $time);
                abort_run();
            end
            @(negedge clock);
        end
        @(posedge clock);     // accepted on this edge
        in_valid <= 1'b0;
        n = 0;
        @(negedge clock);
        while (!out_valid) begin
            n++;
            if (n > TIMEOUT) begin
                $display("timeout waiting for out_valid at time %0t", $time);
                abort_run();
            end
            @(negedge clock);
        end
        check_word("pc_out", pc_out, sent_pc);
        check_reg("rd_out", rd_out, dest);
        check_flag("reg_wen_out", reg_wen_out, wr_reg);
    endtask

    task automatic store_op(input rv_mem_pkg::funct3_t f3, input rv_mem_pkg::addr_t a,
                            input rv_mem_pkg::word_t data, input rv_mem_pkg::stage_err_t exp);
        run_instr(1'b0, 1'b1, 1'b0, f3, a, data);
        check_err("err_out", err_out, exp);
        check_word("load_data", load_data, '0);
        if (exp == rv_mem_pkg::ERR_NONE)
            model_store(f3, a, data);
    endtask

    task automatic load_op(input rv_mem_pkg::funct3_t f3, input rv_mem_pkg::addr_t a,
                           input rv_mem_pkg::stage_err_t exp);
        run_instr(1'b1, 1'b0, 1'b1, f3, a, $urandom);
        check_err("err_out", err_out, exp);
        if (exp == rv_mem_pkg::ERR_NONE)
            check_word("load_data", load_data, model_load(f3, a));
        else
            check_word("load_data", load_data, '0);
    endtask

    function automatic rv_mem_pkg::addr_t random_word_addr();
        return ($urandom % (MEM_BYTES / 4)) * 4;
    endfunction

    task automatic fill_memory();
        for (int w = 0; w < MEM_BYTES / 4; w++)
            store_op(rv_mem_pkg::F3_W, w * 4, $urandom, rv_mem_pkg::ERR_NONE);
    endtask

    task automatic word_roundtrip();
        rv_mem_pkg::addr_t a;
        for (int b = 0; b < NUM_BANKS; b++) begin
            repeat (4) begin
                a = (b * BANK_WORDS + $urandom % BANK_WORDS) * 4;
                store_op(rv_mem_pkg::F3_W, a, $urandom, rv_mem_pkg::ERR_NONE);
                load_op(rv_mem_pkg::F3_W, a, rv_mem_pkg::ERR_NONE);
            end
        end
    endtask

    task automatic partial_stores();
        rv_mem_pkg::addr_t base;
        repeat (4) begin
            base = random_word_addr();
            for (int off = 0; off < 4; off++) begin
                store_op(rv_mem_pkg::F3_B, base + off, $urandom, rv_mem_pkg::ERR_NONE);
                load_op(rv_mem_pkg::F3_W, base, rv_mem_pkg::ERR_NONE);
            end
            for (int off = 0; off < 4; off += 2) begin
                store_op(rv_mem_pkg::F3_H, base + off, $urandom, rv_mem_pkg::ERR_NONE);
                load_op(rv_mem_pkg::F3_W, base, rv_mem_pkg::ERR_NONE);
            end
        end
    endtask

    task automatic load_extension();
        rv_mem_pkg::addr_t base;
        rv_mem_pkg::word_t pattern [2];
        pattern[0] = 32'h80f1_7f8e;     // mixed sign bits per lane
        pattern[1] = $urandom;
        for (int p = 0; p < 2; p++) begin
            base = random_word_addr();
            store_op(rv_mem_pkg::F3_W, base, pattern[p], rv_mem_pkg::ERR_NONE);
            for (int off = 0; off < 4; off++) begin
                load_op(rv_mem_pkg::F3_B, base + off, rv_mem_pkg::ERR_NONE);
                load_op(rv_mem_pkg::F3_BU, base + off, rv_mem_pkg::ERR_NONE);
            end
            for (int off = 0; off < 4; off += 2) begin
                load_op(rv_mem_pkg::F3_H, base + off, rv_mem_pkg::ERR_NONE);
                load_op(rv_mem_pkg::F3_HU, base + off, rv_mem_pkg::ERR_NONE);
            end
        end
    endtask

    task automatic unmapped_access();
        rv_mem_pkg::addr_t bad [3];
        bad[0] = MEM_BYTES;
        bad[1] = MEM_BYTES + ($urandom % 1024) * 4;
        bad[2] = 32'hffff_fffc;
        foreach (bad[i]) begin
            load_op(rv_mem_pkg::F3_W, bad[i], rv_mem_pkg::ERR_BUS);
            store_op(rv_mem_pkg::F3_W, bad[i], $urandom, rv_mem_pkg::ERR_BUS);
            load_op(rv_mem_pkg::F3_W, random_word_addr(), rv_mem_pkg::ERR_NONE);
        end
    endtask

    task automatic misaligned_access();
        rv_mem_pkg::addr_t base;
        base = random_word_addr();
        for (int off = 1; off < 4; off += 2) begin
            load_op(rv_mem_pkg::F3_H, base + off, rv_mem_pkg::ERR_MISALIGN);
            load_op(rv_mem_pkg::F3_HU, base + off, rv_mem_pkg::ERR_MISALIGN);
            store_op(rv_mem_pkg::F3_H, base + off, $urandom, rv_mem_pkg::ERR_MISALIGN);
        end
        for (int off = 1; off < 4; off++) begin
            load_op(rv_mem_pkg::F3_W, base + off, rv_mem_pkg::ERR_MISALIGN);
            store_op(rv_mem_pkg::F3_W, base + off, $urandom, rv_mem_pkg::ERR_MISALIGN);
        end
        load_op(rv_mem_pkg::F3_W, base, rv_mem_pkg::ERR_NONE);    // word untouched
    endtask

    task automatic passthrough_backpressure();
        rv_mem_pkg::addr_t    held_pc;
        rv_mem_pkg::reg_idx_t held_rd;
        rv_mem_pkg::addr_t    next_pc;
        rv_mem_pkg::reg_idx_t next_rd;
        repeat (4) begin
            run_instr(1'b0, 1'b0, 1'($urandom), rv_mem_pkg::F3_W, $urandom, $urandom);
            check_err("err_out", err_out, rv_mem_pkg::ERR_NONE);
        end
        @(posedge clock);
        out_ready <= 1'b0;
        run_instr(1'b0, 1'b0, 1'b1, rv_mem_pkg::F3_B, $urandom, $urandom);
        held_pc = pc_out;
        held_rd = rd_out;
        next_pc = ~held_pc;
        next_rd = held_rd + 5'd1;
        @(posedge clock);
        in_valid <= 1'b1;    // next instruction waits behind the held result
        reg_wen  <= 1'b0;
        pc       <= next_pc;
        rd       <= next_rd;
        repeat (6) begin
            @(negedge clock);
            check_flag("out_valid", out_valid, 1'b1);
            check_flag("in_ready", in_ready, 1'b0);
            check_word("pc_out", pc_out, held_pc);
            check_reg("rd_out", rd_out, held_rd);
            check_flag("reg_wen_out", reg_wen_out, 1'b1);
        end
        @(posedge clock);
        out_ready <= 1'b1;
        @(negedge clock);
        check_flag("in_ready", in_ready, 1'b1);
        @(posedge clock);    // held result leaves, next one enters
        in_valid <= 1'b0;
        @(negedge clock);
        check_flag("out_valid", out_valid, 1'b1);
        check_word("pc_out", pc_out, next_pc);
        check_reg("rd_out", rd_out, next_rd);
        check_flag("reg_wen_out", reg_wen_out, 1'b0);
    endtask

    initial begin
        void'($urandom(58443));
        reset      = 1'b1;
        in_valid   = 1'b0;
        out_ready  = 1'b1;
        mem_ren    = 1'b0;
        mem_wen    = 1'b0;
        reg_wen    = 1'b0;
        funct3     = rv_mem_pkg::F3_W;
        pc         = '0;
        addr       = '0;
        store_data = '0;
        rd         = '0;
        repeat (8) @(posedge clock);
        reset <= 1'b0;
        fill_memory();
        word_roundtrip();
        partial_stores();
        load_extension();
        unmapped_access();
        misaligned_access();
        passthrough_backpressure();
        repeat (4) @(posedge clock);
        if (u_mem_stage_top.u_mem_stage_assertions.fail_count == 0)
            $display("TEST RESULT: PASS");
        else
            $display("TEST RESULT: FAIL");
        $finish;
    end

endmodule

// ==== mem_stage.f ====
src/rv_mem_pkg.sv
src/mem_bus_pkg.sv
src/mem_req_if.sv
src/mem_rsp_if.sv
src/lsu_stage.sv
src/bank_router.sv
src/mem_bank.sv
src/resp_merge.sv
src/mem_stage_top.sv
bench/mem_stage_assertions.sv
bench/mem_stage_tb.sv

// ==== src/bank_router.sv ====
////////////////////////////////////////////////////////////////////////////
// bank_router
// decodes the request address and steers it to one bank, or accepts
// it at once when unmapped; registers the target for the merger
////////////////////////////////////////////////////////////////////////////
module bank_router #(
    parameter  int NUM_BANKS  = 4,
    parameter  int BANK_WORDS = 64,
    localparam int BANK_BITS  = (NUM_BANKS > 1) ? $clog2(NUM_BANKS) : 1
) (
    input  logic                 clock,
    input  logic                 reset,
    mem_req_if.responder         lsu_req,
    mem_req_if.requester         bank_req [NUM_BANKS],
    output logic [BANK_BITS-1:0] route_bank,
    output logic                 route_unmapped,
    output logic                 route_valid
);

    localparam int WORD_BITS = $clog2(BANK_WORDS);

    logic [BANK_BITS-1:0] sel;
    logic                 unmapped;
    logic                 fire;
    logic [NUM_BANKS-1:0] bank_ready;

    assign sel      = BANK_BITS'(mem_bus_pkg::bank_sel(lsu_req.addr, WORD_BITS));
    assign unmapped = mem_bus_pkg::out_of_range(lsu_req.addr, NUM_BANKS * BANK_WORDS * 4);

    for (genvar g = 0; g < NUM_BANKS; g++) begin : g_steer
        assign bank_req[g].valid = lsu_req.valid & ~unmapped & (sel == g);
        assign bank_req[g].write = lsu_req.write;
        assign bank_req[g].addr  = lsu_req.addr;
        assign bank_req[g].wdata = lsu_req.wdata;
        assign bank_req[g].strb  = lsu_req.strb;
        assign bank_ready[g]     = bank_req[g].ready;
    end

    assign lsu_req.ready = unmapped | bank_ready[sel];   // error path never stalls
    assign fire          = lsu_req.valid & lsu_req.ready;

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            route_valid    <= 1'b0;
            route_bank     <= '0;
            route_unmapped <= 1'b0;
        end else begin
            route_valid <= fire;
            if (fire) begin
                route_bank     <= sel;
                route_unmapped <= unmapped;
            end
        end
    end

endmodule

// ==== src/lsu_stage.sv ====
////////////////////////////////////////////////////////////////////////////
// lsu_stage
// load/store unit: latches one instruction, issues a single memory
// request, aligns store data and strobes, extends load data
////////////////////////////////////////////////////////////////////////////
module lsu_stage (
    input  logic                   clock,
    input  logic                   reset,
    input  logic                   in_valid,
    output logic                   in_ready,
    input  rv_mem_pkg::addr_t      pc,
    input  logic                   mem_ren,
    input  logic                   mem_wen,
    input  logic                   reg_wen,
    input  rv_mem_pkg::funct3_t    funct3,
    input  rv_mem_pkg::addr_t      addr,
    input  rv_mem_pkg::word_t      store_data,
    input  rv_mem_pkg::reg_idx_t   rd,
    output logic                   out_valid,
    input  logic                   out_ready,
    output rv_mem_pkg::addr_t      pc_out,
    output rv_mem_pkg::reg_idx_t   rd_out,
    output logic                   reg_wen_out,
    output rv_mem_pkg::word_t      load_data,
    output rv_mem_pkg::stage_err_t err_out,
    mem_req_if.requester           req,
    mem_rsp_if.requester           rsp
);

    rv_mem_pkg::addr_t      pc_q;
    rv_mem_pkg::addr_t      addr_q;
    rv_mem_pkg::word_t      store_data_q;
    rv_mem_pkg::reg_idx_t   rd_q;
    rv_mem_pkg::funct3_t    funct3_q;
    logic                   mem_ren_q;
    logic                   mem_wen_q;
    logic                   reg_wen_q;
    rv_mem_pkg::word_t      load_data_q;
    rv_mem_pkg::stage_err_t err_q;
    logic                   busy;           // waiting on the bus
    logic                   req_valid_q;
    logic                   accept;
    logic                   misalign;
    logic                   issue;
    logic                   rsp_fire;
    logic [1:0]             off;
    logic [7:0]             lane_b;
    logic [15:0]            lane_h;
    rv_mem_pkg::word_t      load_ext;

    assign in_ready = ~busy & (~out_valid | out_ready);
    assign accept   = in_valid & in_ready;
    assign issue    = (mem_ren | mem_wen) & ~misalign;
    assign rsp_fire = rsp.valid & rsp.ready;

    always_comb begin
        misalign = 1'b0;
        if (mem_ren | mem_wen) begin
            case (funct3)
                rv_mem_pkg::F3_H, rv_mem_pkg::F3_HU: misalign = addr[0];
                rv_mem_pkg::F3_W:                    misalign = |addr[1:0];
                default:                             misalign = 1'b0;
            endcase
        end
    end

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            busy        <= 1'b0;
            req_valid_q <= 1'b0;
            out_valid   <= 1'b0;
            err_q       <= rv_mem_pkg::ERR_NONE;
        end else if (accept) begin
            busy        <= issue;
            req_valid_q <= issue;
            out_valid   <= ~issue;          // pass-through or misaligned
            err_q       <= misalign ? rv_mem_pkg::ERR_MISALIGN : rv_mem_pkg::ERR_NONE;
        end else begin
            if (out_valid & out_ready)
                out_valid <= 1'b0;
            if (req.valid & req.ready)
                req_valid_q <= 1'b0;
            if (rsp_fire) begin
                busy      <= 1'b0;
                out_valid <= 1'b1;
                if (rsp.resp != mem_bus_pkg::RSP_OKAY)
                    err_q <= rv_mem_pkg::ERR_BUS;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (accept) begin
            pc_q         <= pc;
            addr_q       <= addr;
            store_data_q <= store_data;
            rd_q         <= rd;
            funct3_q     <= funct3;
            mem_ren_q    <= mem_ren;
            mem_wen_q    <= mem_wen;
            reg_wen_q    <= reg_wen;
            load_data_q  <= '0;
        end else if (rsp_fire) begin
            load_data_q  <= (mem_ren_q && rsp.resp == mem_bus_pkg::RSP_OKAY) ? load_ext : '0;
        end
    end

    assign off = addr_q[1:0];

    // store lane placement
    always_comb begin
        case (funct3_q)
            rv_mem_pkg::F3_B: begin
                req.strb  = 4'b0001 << off;
                req.wdata = store_data_q << {off, 3'b000};
            end
            rv_mem_pkg::F3_H: begin
                req.strb  = 4'b0011 << {off[1], 1'b0};
                req.wdata = store_data_q << {off[1], 4'b0000};
            end
            default: begin
                req.strb  = 4'b1111;
                req.wdata = store_data_q;
            end
        endcase
    end

    assign req.valid = req_valid_q;
    assign req.write = mem_wen_q;
    assign req.addr  = addr_q;
    assign rsp.ready = busy;

    assign lane_b = rsp.rdata[{off, 3'b000} +: 8];
    assign lane_h = rsp.rdata[{off[1], 4'b0000} +: 16];

    always_comb begin
        case (funct3_q)
            rv_mem_pkg::F3_B:  load_ext = {{24{lane_b[7]}}, lane_b};
            rv_mem_pkg::F3_H:  load_ext = {{16{lane_h[15]}}, lane_h};
            rv_mem_pkg::F3_BU: load_ext = {24'd0, lane_b};
            rv_mem_pkg::F3_HU: load_ext = {16'd0, lane_h};
            default:           load_ext = rsp.rdata;
        endcase
    end

    assign pc_out      = pc_q;
    assign rd_out      = rd_q;
    assign reg_wen_out = reg_wen_q;
    assign load_data   = load_data_q;
    assign err_out     = err_q;

endmodule

// ==== src/mem_bank.sv ====
////////////////////////////////////////////////////////////////////////////
// mem_bank
// one word-wide SRAM bank with byte strobes; answers each request a
// fixed number of cycles after accepting it
////////////////////////////////////////////////////////////////////////////
module mem_bank #(
    parameter int BANK_WORDS   = 64,
    parameter int BANK_LATENCY = 2
) (
    input  logic         clock,
    input  logic         reset,
    mem_req_if.responder req,
    mem_rsp_if.responder rsp
);

    localparam int WORD_BITS = $clog2(BANK_WORDS);
    localparam int CNT_BITS  = $clog2(BANK_LATENCY + 1);

    rv_mem_pkg::word_t     mem [BANK_WORDS];
    rv_mem_pkg::word_t     rdata_q;
    logic [WORD_BITS-1:0]  idx;
    logic [CNT_BITS-1:0]   count;
    logic                  busy;
    logic                  req_fire;

    assign idx       = WORD_BITS'(mem_bus_pkg::word_sel(req.addr));
    assign req.ready = ~busy;
    assign req_fire  = req.valid & ~busy;

    assign rsp.valid = busy & (count == '0);
    assign rsp.rdata = rdata_q;
    assign rsp.resp  = mem_bus_pkg::RSP_OKAY;

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            busy  <= 1'b0;
            count <= '0;
        end else if (req_fire) begin
            busy  <= 1'b1;
            count <= CNT_BITS'(BANK_LATENCY - 1);
        end else if (busy && count != '0) begin
            count <= count - 1'b1;
        end else if (rsp.valid & rsp.ready) begin
            busy  <= 1'b0;
        end
    end

    // old word comes back for writes too
    always_ff @(posedge clock) begin
        if (req_fire) begin
            rdata_q <= mem[idx];
            if (req.write) begin
                for (int b = 0; b < 4; b++) begin
                    if (req.strb[b])
                        mem[idx][8*b +: 8] <= req.wdata[8*b +: 8];
                end
            end
        end
    end

endmodule

// ==== src/mem_bus_pkg.sv ====
////////////////////////////////////////////////////////////////////////////
// mem_bus_pkg
// response codes and address helpers of the internal memory bus
////////////////////////////////////////////////////////////////////////////
package mem_bus_pkg;

    typedef enum logic [1:0] {
        RSP_OKAY   = 2'b00,
        RSP_DECERR = 2'b11
    } rsp_t;

    typedef logic [3:0] strb_t;

    // word address, low bits pick the word inside a bank
    function automatic logic [31:0] word_sel(input rv_mem_pkg::addr_t addr);
        return addr >> 2;
    endfunction

    // bits above the in-bank word index
    function automatic logic [31:0] bank_sel(input rv_mem_pkg::addr_t addr,
                                             input int unsigned word_bits);
        return addr >> (word_bits + 2);
    endfunction

    function automatic logic out_of_range(input rv_mem_pkg::addr_t addr,
                                          input longint unsigned limit);
        return longint'(addr) >= limit;
    endfunction

endpackage

// ==== src/mem_req_if.sv ====
////////////////////////////////////////////////////////////////////////////
// mem_req_if
// request channel of the memory bus, valid/ready handshake
////////////////////////////////////////////////////////////////////////////
interface mem_req_if;

    logic                  valid;
    logic                  ready;
    logic                  write;
    rv_mem_pkg::addr_t     addr;
    rv_mem_pkg::word_t     wdata;
    mem_bus_pkg::strb_t    strb;

    modport requester (output valid, write, addr, wdata, strb, input ready);
    modport responder (input valid, write, addr, wdata, strb, output ready);

endinterface

// ==== src/mem_rsp_if.sv ====
////////////////////////////////////////////////////////////////////////////
// mem_rsp_if
// response channel of the memory bus, valid/ready handshake
////////////////////////////////////////////////////////////////////////////
interface mem_rsp_if;

    logic                  valid;
    logic                  ready;
    rv_mem_pkg::word_t     rdata;
    mem_bus_pkg::rsp_t     resp;

    modport requester (input valid, rdata, resp, output ready);
    modport responder (output valid, rdata, resp, input ready);

endinterface

// ==== src/mem_stage_top.sv ====
////////////////////////////////////////////////////////////////////////////
// mem_stage_top
// memory-access stage: load/store unit, bank router, SRAM banks and
// response merger
////////////////////////////////////////////////////////////////////////////
module mem_stage_top #(
    parameter int NUM_BANKS    = 4,
    parameter int BANK_WORDS   = 64,
    parameter int BANK_LATENCY = 2
) (
    input  logic                   clock,
    input  logic                   reset,
    input  logic                   in_valid,
    output logic                   in_ready,
    input  rv_mem_pkg::addr_t      pc,
    input  logic                   mem_ren,
    input  logic                   mem_wen,
    input  logic                   reg_wen,
    input  rv_mem_pkg::funct3_t    funct3,
    input  rv_mem_pkg::addr_t      addr,
    input  rv_mem_pkg::word_t      store_data,
    input  rv_mem_pkg::reg_idx_t   rd,
    output logic                   out_valid,
    input  logic                   out_ready,
    output rv_mem_pkg::addr_t      pc_out,
    output rv_mem_pkg::reg_idx_t   rd_out,
    output logic                   reg_wen_out,
    output rv_mem_pkg::word_t      load_data,
    output rv_mem_pkg::stage_err_t err_out
);

    localparam int BANK_BITS = (NUM_BANKS > 1) ? $clog2(NUM_BANKS) : 1;

    logic [BANK_BITS-1:0] route_bank;
    logic                 route_unmapped;
    logic                 route_valid;

    mem_req_if lsu_req ();
    mem_rsp_if lsu_rsp ();
    mem_req_if bank_req [NUM_BANKS] ();
    mem_rsp_if bank_rsp [NUM_BANKS] ();

    lsu_stage u_lsu_stage (
        .clock, .reset, .in_valid, .in_ready, .pc, .mem_ren, .mem_wen, .reg_wen,
        .funct3, .addr, .store_data, .rd, .out_valid, .out_ready, .pc_out, .rd_out,
        .reg_wen_out, .load_data, .err_out, .req(lsu_req), .rsp(lsu_rsp)
    );

    bank_router #(.NUM_BANKS(NUM_BANKS), .BANK_WORDS(BANK_WORDS)) u_bank_router (
        .clock, .reset, .lsu_req(lsu_req), .bank_req(bank_req),
        .route_bank, .route_unmapped, .route_valid
    );

    for (genvar g = 0; g < NUM_BANKS; g++) begin : g_bank
        mem_bank #(.BANK_WORDS(BANK_WORDS), .BANK_LATENCY(BANK_LATENCY)) u_mem_bank (
            .clock, .reset, .req(bank_req[g]), .rsp(bank_rsp[g])
        );
    end

    resp_merge #(.NUM_BANKS(NUM_BANKS)) u_resp_merge (
        .clock, .reset, .route_bank, .route_unmapped, .route_valid,
        .bank_rsp(bank_rsp), .lsu_rsp(lsu_rsp)
    );

endmodule

// ==== src/resp_merge.sv ====
////////////////////////////////////////////////////////////////////////////
// resp_merge
// forwards the routed bank's response to the unit; answers unmapped
// requests with a decode error
////////////////////////////////////////////////////////////////////////////
module resp_merge #(
    parameter  int NUM_BANKS = 4,
    localparam int BANK_BITS = (NUM_BANKS > 1) ? $clog2(NUM_BANKS) : 1
) (
    input  logic                 clock,
    input  logic                 reset,
    input  logic [BANK_BITS-1:0] route_bank,
    input  logic                 route_unmapped,
    input  logic                 route_valid,
    mem_rsp_if.requester         bank_rsp [NUM_BANKS],
    mem_rsp_if.responder         lsu_rsp
);

    logic                 pend_valid;
    logic [BANK_BITS-1:0] pend_bank;
    logic                 pend_unmapped;
    logic                 cur_active;
    logic [BANK_BITS-1:0] cur_bank;
    logic                 cur_unmapped;
    logic [NUM_BANKS-1:0] bank_valid;
    rv_mem_pkg::word_t    bank_rdata [NUM_BANKS];
    mem_bus_pkg::rsp_t    bank_resp [NUM_BANKS];

    // fresh route bypasses the pending register
    assign cur_active   = route_valid | pend_valid;
    assign cur_bank     = route_valid ? route_bank : pend_bank;
    assign cur_unmapped = route_valid ? route_unmapped : pend_unmapped;

    for (genvar g = 0; g < NUM_BANKS; g++) begin : g_drain
        assign bank_valid[g]     = bank_rsp[g].valid;
        assign bank_rdata[g]     = bank_rsp[g].rdata;
        assign bank_resp[g]      = bank_rsp[g].resp;
        assign bank_rsp[g].ready = lsu_rsp.ready & cur_active & ~cur_unmapped &
                                   (cur_bank == g);
    end

    assign lsu_rsp.valid = cur_active & (cur_unmapped | bank_valid[cur_bank]);
    assign lsu_rsp.rdata = cur_unmapped ? '0 : bank_rdata[cur_bank];
    assign lsu_rsp.resp  = cur_unmapped ? mem_bus_pkg::RSP_DECERR : bank_resp[cur_bank];

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            pend_valid    <= 1'b0;
            pend_bank     <= '0;
            pend_unmapped <= 1'b0;
        end else begin
            if (lsu_rsp.valid & lsu_rsp.ready)
                pend_valid <= 1'b0;
            else if (route_valid)
                pend_valid <= 1'b1;
            if (route_valid) begin
                pend_bank     <= route_bank;
                pend_unmapped <= route_unmapped;
            end
        end
    end

endmodule

// ==== src/rv_mem_pkg.sv ====
////////////////////////////////////////////////////////////////////////////
// rv_mem_pkg
// RV32 load/store encodings, data and address types, and the status
// codes that the memory stage reports for a retiring instruction
////////////////////////////////////////////////////////////////////////////
package rv_mem_pkg;

    typedef logic [31:0] word_t;
    typedef logic [31:0] addr_t;
    typedef logic [4:0]  reg_idx_t;
    typedef logic [2:0]  funct3_t;

    // load/store width, RISC-V funct3 encoding
    localparam funct3_t F3_B  = 3'b000;
    localparam funct3_t F3_H  = 3'b001;
    localparam funct3_t F3_W  = 3'b010;
    localparam funct3_t F3_BU = 3'b100;
    localparam funct3_t F3_HU = 3'b101;

    typedef enum logic [1:0] {
        ERR_NONE     = 2'b00,
        ERR_MISALIGN = 2'b01,    // odd lh/lhu/sh or unaligned word
        ERR_BUS      = 2'b10     // non-okay bus response
    } stage_err_t;

endpackage
